// File: hw/i2c_bus_pkg.sv
// Bus level definitions for the I2C write engine
// Tick timing, sequence step numbers and the layout of one transfer word
// Imported by the tick divider, the write sequencer and the configuration FSM
`default_nettype none

package i2c_bus_pkg;

	// System clocks per half SCL phase, small for simulation
	localparam int unsigned I2C_TICK_DIV = 4;
	localparam int unsigned I2C_TICK_CNT_W = $clog2(I2C_TICK_DIV);
	localparam logic [I2C_TICK_CNT_W-1:0] I2C_TICK_RELOAD = I2C_TICK_CNT_W'(I2C_TICK_DIV - 1);

	typedef logic [5:0] i2c_step_t; // Sequencer step number

	localparam i2c_step_t I2C_STEP_IDLE = 6'd63; // Parked between transfers
	localparam i2c_step_t I2C_STEP_LAST = 6'd32; // Stop step
	localparam i2c_step_t I2C_STEP_GATE_FIRST = 6'd4; // First clocked bit
	localparam i2c_step_t I2C_STEP_GATE_LAST = 6'd30; // Last clocked slot

	// Acknowledge slots after each byte
	localparam i2c_step_t I2C_STEP_ACK1 = 6'd12;
	localparam i2c_step_t I2C_STEP_ACK2 = 6'd21;
	localparam i2c_step_t I2C_STEP_ACK3 = 6'd30;

	// Word following the device address
	typedef union packed {
		struct packed {
			logic [7:0] reg_byte;   // First byte on the wire
			logic [7:0] data_byte;  // Second byte on the wire
		} wire_view;
		struct packed {
			logic [6:0] reg_addr;   // Codec register number
			logic [8:0] reg_value;  // 9 bit register contents
		} codec_view;
	} reg_word_u;

	typedef struct packed {
		logic [7:0] dev_addr; // Slave address and write bit
		reg_word_u  reg_word;
	} xfer_word_t;

endpackage

`default_nettype wire

// File: hw/codec_cfg_pkg.sv
// Codec side definitions for the configuration master
// Device address, the fixed register table, retry limit and FSM encodings
// Imported by the configuration FSM and used for the status index type
`default_nettype none

package codec_cfg_pkg;

	localparam logic [7:0] CODEC_DEV_ADDR = 8'h34; // 7 bit 1A plus write bit
	localparam int unsigned CFG_COUNT = 10;
	localparam int unsigned CFG_RETRY_MAX = 3; // Re-issues after a NACK
	localparam int unsigned CFG_RETRY_W = $clog2(CFG_RETRY_MAX + 1);
	localparam int unsigned CFG_INDEX_W = $clog2(CFG_COUNT + 1);

	typedef logic [CFG_INDEX_W-1:0] cfg_index_t;

	localparam cfg_index_t CFG_LAST = cfg_index_t'(CFG_COUNT - 1);

	// Configuration FSM states
	localparam int unsigned CFG_ST_W = 3;
	localparam logic [CFG_ST_W-1:0] CFG_ST_IDLE = 3'd0;
	localparam logic [CFG_ST_W-1:0] CFG_ST_ISSUE = 3'd1;
	localparam logic [CFG_ST_W-1:0] CFG_ST_WAIT = 3'd2;
	localparam logic [CFG_ST_W-1:0] CFG_ST_FINISHED = 3'd3;
	localparam logic [CFG_ST_W-1:0] CFG_ST_FAILED = 3'd4;

	// Builds a table entry through the codec view
	function automatic i2c_bus_pkg::reg_word_u cfg_entry(input logic [6:0] addr,
			input logic [8:0] value);
		i2c_bus_pkg::reg_word_u w;
		w.codec_view.reg_addr = addr;
		w.codec_view.reg_value = value;
		return w;
	endfunction

	localparam i2c_bus_pkg::reg_word_u CFG_TABLE [CFG_COUNT] = '{
		cfg_entry(7'h0f, 9'h000), // Soft reset
		cfg_entry(7'h00, 9'h017), // Left line in, 0 dB
		cfg_entry(7'h01, 9'h017), // Right line in, 0 dB
		cfg_entry(7'h02, 9'h079), // Left headphone
		cfg_entry(7'h03, 9'h079), // Right headphone
		cfg_entry(7'h04, 9'h012), // DAC selected
		cfg_entry(7'h05, 9'h000), // No de-emphasis, unmuted
		cfg_entry(7'h06, 9'h000), // Everything powered
		cfg_entry(7'h07, 9'h042), // I2S, master mode
		cfg_entry(7'h09, 9'h001)  // Activate interface
	};

endpackage

`default_nettype wire

// File: hw/i2c_xfer_if.sv
// Transfer request channel between the configuration FSM and the write engine
// One-cycle go with its word, answered by a one-cycle done with the NACK flag
`timescale 1ns/1ps
`default_nettype none

interface i2c_xfer_if;

	logic                   go;    // Start strobe
	i2c_bus_pkg::xfer_word_t word; // Valid with go
	logic                   done;  // End strobe
	logic                   nack;  // Valid with done

	// Configuration side
	modport master (
		output go,
		output word,
		input  done,
		input  nack
	);

	// Write engine side
	modport engine (
		input  go,
		input  word,
		output done,
		output nack
	);

endinterface

`default_nettype wire

// File: hw/i2c_tick_gen.sv
// Bus timing source for the I2C write engine
// tick pulses once every I2C_TICK_DIV clocks, phase_hi flips after each tick
// One tick closes every SCL half, so SCL and SDA edges stay on the same grid
`timescale 1ns/1ps
`default_nettype none

module i2c_tick_gen (
	input  logic CLOCK,
	input  logic RESET,
	output logic tick,
	output logic phase_hi
);
	import i2c_bus_pkg::*;

	logic [I2C_TICK_CNT_W-1:0] cnt; // Clocks left in this half

	always_ff @(posedge CLOCK) begin
		if (!RESET) begin
			cnt <= I2C_TICK_RELOAD;
			tick <= 1'b0;
			phase_hi <= 1'b0; // Start in a low half
		end else begin
			tick <= (cnt == '0);
			if (cnt == '0)
				cnt <= I2C_TICK_RELOAD;
			else
				cnt <= cnt - 1'b1;
			if (tick)
				phase_hi <= ~phase_hi; // Next half begins
		end
	end

endmodule

`default_nettype wire

// File: hw/i2c_write_ctrl.sv
// Three byte I2C write engine
// Latches a 24 bit word on go and runs steps 0 to 32 on the bus tick
// Start, address, register and data bytes with acknowledge slots, then stop
// done pulses at the end, with nack set if any slot saw SDA high
`timescale 1ns/1ps
`default_nettype none

module i2c_write_ctrl (
	input  logic       CLOCK,
	input  logic       RESET,
	input  logic       tick,
	input  logic       phase_hi,
	i2c_xfer_if.engine xfer,
	output logic       i2c_sclk,
	output logic       i2c_sda_oe,  // 1 pulls SDA low
	input  logic       i2c_sda_in
);
	import i2c_bus_pkg::*;

	i2c_step_t  step;       // Current step
	i2c_step_t  step_next;
	logic       armed;      // Word latched until a step boundary
	logic       accept;     // go taken this cycle
	logic       step_end;   // Tick closing a high half
	logic       sda_bit;    // Wanted SDA level where 1 releases
	logic       ack_slot;   // Acknowledge slot aligned with i2c_sda_oe
	logic       nack_q;     // Sticky over the three slots
	logic       done_q;
	xfer_word_t word_q;

	assign step_end = tick & phase_hi;
	assign accept = xfer.go && (step == I2C_STEP_IDLE) && !armed; // Busy go is dropped

	// SCL level for a step and half
	function automatic logic scl_level(input i2c_step_t s, input logic ph);
		if (s >= I2C_STEP_GATE_FIRST && s <= I2C_STEP_GATE_LAST)
			return ph; // Clocked bits and acks
		else if (s == 6'd2 || s == 6'd3 || s == 6'd31)
			return 1'b0; // Held low around the frame
		else
			return 1'b1; // Idle, start and stop
	endfunction

	always_comb begin
		step_next = step;
		if (step_end) begin
			if (step == I2C_STEP_IDLE)
				step_next = armed ? 6'd0 : I2C_STEP_IDLE;
			else if (step == I2C_STEP_LAST)
				step_next = I2C_STEP_IDLE; // Back to park
			else
				step_next = step + 6'd1;
		end
	end

	// SDA per step, bytes go MSB first
	always_comb begin
		case (step)
			6'd0:  sda_bit = 1'b1;
			6'd1:  sda_bit = 1'b0; // Start under high SCL
			6'd2:  sda_bit = 1'b0;
			6'd3:  sda_bit = 1'b0;
			6'd4:  sda_bit = word_q.dev_addr[7];
			6'd5:  sda_bit = word_q.dev_addr[6];
			6'd6:  sda_bit = word_q.dev_addr[5];
			6'd7:  sda_bit = word_q.dev_addr[4];
			6'd8:  sda_bit = word_q.dev_addr[3];
			6'd9:  sda_bit = word_q.dev_addr[2];
			6'd10: sda_bit = word_q.dev_addr[1];
			6'd11: sda_bit = word_q.dev_addr[0]; // Write bit
			I2C_STEP_ACK1: sda_bit = 1'b1;
			6'd13: sda_bit = word_q.reg_word.wire_view.reg_byte[7];
			6'd14: sda_bit = word_q.reg_word.wire_view.reg_byte[6];
			6'd15: sda_bit = word_q.reg_word.wire_view.reg_byte[5];
			6'd16: sda_bit = word_q.reg_word.wire_view.reg_byte[4];
			6'd17: sda_bit = word_q.reg_word.wire_view.reg_byte[3];
			6'd18: sda_bit = word_q.reg_word.wire_view.reg_byte[2];
			6'd19: sda_bit = word_q.reg_word.wire_view.reg_byte[1];
			6'd20: sda_bit = word_q.reg_word.wire_view.reg_byte[0];
			I2C_STEP_ACK2: sda_bit = 1'b1;
			6'd22: sda_bit = word_q.reg_word.wire_view.data_byte[7];
			6'd23: sda_bit = word_q.reg_word.wire_view.data_byte[6];
			6'd24: sda_bit = word_q.reg_word.wire_view.data_byte[5];
			6'd25: sda_bit = word_q.reg_word.wire_view.data_byte[4];
			6'd26: sda_bit = word_q.reg_word.wire_view.data_byte[3];
			6'd27: sda_bit = word_q.reg_word.wire_view.data_byte[2];
			6'd28: sda_bit = word_q.reg_word.wire_view.data_byte[1];
			6'd29: sda_bit = word_q.reg_word.wire_view.data_byte[0];
			I2C_STEP_ACK3: sda_bit = 1'b1;
			6'd31: sda_bit = 1'b0; // Low ahead of the stop
			I2C_STEP_LAST: sda_bit = phase_hi; // Stop rises on the high half
			default: sda_bit = 1'b1; // Parked with the bus released
		endcase
	end

	always_ff @(posedge CLOCK) begin
		if (!RESET) begin
			step <= I2C_STEP_IDLE;
			armed <= 1'b0;
			i2c_sclk <= 1'b1;
			i2c_sda_oe <= 1'b0;
			ack_slot <= 1'b0;
			nack_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= step_end && (step == I2C_STEP_LAST); // One clock after step 32
			// SDA trails the step by a clock, so it moves while SCL is low
			i2c_sda_oe <= ~sda_bit;
			ack_slot <= (step == I2C_STEP_ACK1) || (step == I2C_STEP_ACK2) ||
				(step == I2C_STEP_ACK3);
			if (tick) begin
				step <= step_next;
				i2c_sclk <= scl_level(step_next, ~phase_hi); // Level of the coming half
			end
			if (accept)
				armed <= 1'b1;
			else if (step_end && step == I2C_STEP_IDLE)
				armed <= 1'b0; // Sequence launched
			if (step_end && step == I2C_STEP_IDLE && armed)
				nack_q <= 1'b0; // Fresh transfer
			else if (step_end && ack_slot)
				nack_q <= nack_q | i2c_sda_in; // Sample at the end of high SCL
		end
	end

	always_ff @(posedge CLOCK) begin
		if (accept)
			word_q <= xfer.word;
	end

	assign xfer.done = done_q;
	assign xfer.nack = nack_q;

endmodule

`default_nettype wire

// File: hw/codec_cfg_regs.sv
// Codec configuration FSM
// On start, writes every CFG_TABLE entry through the I2C write engine in order
// A refused entry is re-issued up to CFG_RETRY_MAX times before giving up
// Status is busy, done or fail, with cfg_index naming the current entry
`timescale 1ns/1ps
`default_nettype none

module codec_cfg_regs (
	input  logic                      CLOCK,
	input  logic                      RESET,
	input  logic                      start,
	i2c_xfer_if.master                xfer,
	output logic                      cfg_busy,
	output logic                      cfg_done,
	output logic                      cfg_fail,
	output codec_cfg_pkg::cfg_index_t cfg_index
);
	import i2c_bus_pkg::*;
	import codec_cfg_pkg::*;

	logic [CFG_ST_W-1:0]    state;
	logic [CFG_RETRY_W-1:0] retry; // Re-issues of this entry so far

	always_ff @(posedge CLOCK) begin
		if (!RESET) begin
			state <= CFG_ST_IDLE;
			cfg_index <= '0;
			retry <= '0;
		end else begin
			case (state)
				CFG_ST_IDLE, CFG_ST_FINISHED, CFG_ST_FAILED: begin
					if (start) begin // Always from entry 0
						cfg_index <= '0;
						retry <= '0;
						state <= CFG_ST_ISSUE;
					end
				end
				CFG_ST_ISSUE: state <= CFG_ST_WAIT; // go lasts this one cycle
				CFG_ST_WAIT: begin
					if (xfer.done) begin
						if (!xfer.nack) begin
							retry <= '0;
							if (cfg_index == CFG_LAST) begin
								state <= CFG_ST_FINISHED;
							end else begin
								cfg_index <= cfg_index + 1'b1;
								state <= CFG_ST_ISSUE;
							end
						end else if (retry == CFG_RETRY_W'(CFG_RETRY_MAX)) begin
							state <= CFG_ST_FAILED; // Index stays on the refused entry
						end else begin
							retry <= retry + 1'b1;
							state <= CFG_ST_ISSUE; // Same entry again
						end
					end
				end
				default: state <= CFG_ST_IDLE;
			endcase
		end
	end

	// Request to the engine
	assign xfer.go = (state == CFG_ST_ISSUE);
	assign xfer.word = xfer_word_t'{dev_addr: CODEC_DEV_ADDR, reg_word: CFG_TABLE[cfg_index]};

	assign cfg_busy = (state == CFG_ST_ISSUE) || (state == CFG_ST_WAIT);
	assign cfg_done = (state == CFG_ST_FINISHED);
	assign cfg_fail = (state == CFG_ST_FAILED);

endmodule

`default_nettype wire

// File: hw/codec_cfg_top.sv
// Codec register configuration master, top level
// Pulse start to load the codec, then watch cfg_done or cfg_fail
// SDA is split into a pull-low enable and a sensed level, the board forms the open drain
`timescale 1ns/1ps
`default_nettype none

module codec_cfg_top (
	input  logic                      CLOCK,
	input  logic                      RESET,
	input  logic                      start,
	input  logic                      i2c_sda_in,  // Sensed bus level
	output logic                      i2c_sclk,
	output logic                      i2c_sda_oe,  // Pull SDA low
	output logic                      cfg_busy,
	output logic                      cfg_done,
	output logic                      cfg_fail,
	output codec_cfg_pkg::cfg_index_t cfg_index
);

	logic tick;     // Half phase boundary
	logic phase_hi; // SCL half in progress

	i2c_xfer_if u_xfer ();

	i2c_tick_gen u_tick (
		.CLOCK    (CLOCK),
		.RESET    (RESET),
		.tick     (tick),
		.phase_hi (phase_hi)
	);

	i2c_write_ctrl u_ctrl (
		.CLOCK      (CLOCK),
		.RESET      (RESET),
		.tick       (tick),
		.phase_hi   (phase_hi),
		.xfer       (u_xfer.engine),
		.i2c_sclk   (i2c_sclk),
		.i2c_sda_oe (i2c_sda_oe),
		.i2c_sda_in (i2c_sda_in)
	);

	codec_cfg_regs u_cfg (
		.CLOCK     (CLOCK),
		.RESET     (RESET),
		.start     (start),
		.xfer      (u_xfer.master),
		.cfg_busy  (cfg_busy),
		.cfg_done  (cfg_done),
		.cfg_fail  (cfg_fail),
		.cfg_index (cfg_index)
	);

endmodule

`default_nettype wire

// File: tb/i2c_slave_model.sv
// Behavioural I2C slave for the codec configuration testbench
// Decodes start, 24 data bits with acknowledge slots and stop, logs each word
// Frames numbered refuse_at up to refuse_at+refuse_times-1 get no acknowledge
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model (
	input  logic scl,
	input  logic sda,          // Wired-AND bus level
	input  logic clear,        // Empties the log
	input  int   refuse_at,    // First frame number to refuse
	input  int   refuse_times,
	output logic sda_oe,       // 1 pulls SDA low
	output logic frame_err     // Sticky flag for bad framing
);

	logic [23:0] log_mem [0:63]; // Received words in order
	int          log_count;
	logic        in_frame;
	logic        scl_prev;
	logic        sda_prev;
	logic        scl_up;   // Rise seen and pulse waiting for the fall
	logic        refuse;   // No acks for this frame
	logic [23:0] shift;
	int          rises;
	int          pulses;

	initial begin
		sda_oe = 1'b0;
		frame_err = 1'b0;
		log_count = 0;
		in_frame = 1'b0;
		scl_prev = 1'b1;
		sda_prev = 1'b1;
		scl_up = 1'b0;
		refuse = 1'b0;
		shift = '0;
		rises = 0;
		pulses = 0;
	end

	always @(posedge scl or negedge scl or posedge sda or negedge sda or posedge clear) begin
		if (clear) begin
			log_count = 0;
			in_frame = 1'b0;
			sda_oe = 1'b0;
		end else if (scl && scl_prev && sda_prev && !sda) begin
			if (in_frame && rises > 0)
				frame_err = 1'b1; // Repeated start is not expected
			in_frame = 1'b1; // Start condition
			rises = 0;
			pulses = 0;
			scl_up = 1'b0;
			shift = '0;
			refuse = (log_count >= refuse_at) && (log_count < refuse_at + refuse_times);
		end else if (scl && scl_prev && !sda_prev && sda) begin
			sda_oe = 1'b0;
			if (in_frame) begin
				in_frame = 1'b0;
				if (pulses != 27)
					frame_err = 1'b1; // Wrong number of SCL pulses
				else if (log_count < 64) begin
					log_mem[log_count] = shift;
					log_count = log_count + 1;
				end
			end
		end else if (scl && !scl_prev) begin
			if (in_frame) begin
				if (rises < 27 && (rises % 9) != 8)
					shift = {shift[22:0], sda}; // MSB first
				rises = rises + 1;
				scl_up = 1'b1;
			end
		end else if (!scl && scl_prev) begin
			if (in_frame && scl_up) begin
				pulses = pulses + 1;
				scl_up = 1'b0;
				// Hold SDA low across the coming ack pulse
				sda_oe = (rises < 27) && ((rises % 9) == 8) && !refuse;
			end
		end
		scl_prev = scl;
		sda_prev = sda;
	end

endmodule

`default_nettype wire

// File: tb/codec_cfg_asserts.sv
// Protocol checks on the I2C write engine, bound into every i2c_write_ctrl
// Single cycle done, released bus while parked, no master drive in ack slots
`timescale 1ns/1ps
`default_nettype none

module codec_cfg_asserts (
	input logic                  CLOCK,
	input logic                  RESET,
	input logic                  done,
	input i2c_bus_pkg::i2c_step_t step,
	input logic                  scl,
	input logic                  sda_oe,
	input logic                  ack_slot  // Aligned with sda_oe
);
	import i2c_bus_pkg::*;

	assert property (@(posedge CLOCK) disable iff (!RESET) done |=> !done)
		else $error("done held longer than one cycle");

	// SDA trails the step by one clock
	assert property (@(posedge CLOCK) disable iff (!RESET)
		(step == I2C_STEP_IDLE && $past(step) == I2C_STEP_IDLE) |-> (scl && !sda_oe))
		else $error("bus not released while idle");

	assert property (@(posedge CLOCK) disable iff (!RESET) ack_slot |-> !sda_oe)
		else $error("master pulls SDA low in an acknowledge slot");

endmodule

bind i2c_write_ctrl codec_cfg_asserts u_asserts (
	.CLOCK    (CLOCK),
	.RESET    (RESET),
	.done     (done_q),
	.step     (step),
	.scl      (i2c_sclk),
	.sda_oe   (i2c_sda_oe),
	.ack_slot (ack_slot)
);

`default_nettype wire

// File: tb/codec_cfg_tb.sv
// Testbench for the codec configuration master
// Runs a table of scenarios with refusals, retries, failure and a stray start
// Checks the logged I2C words and the status outputs against the register table
`timescale 1ns/1ps
`default_nettype none

module codec_cfg_tb;
	import i2c_bus_pkg::*;
	import codec_cfg_pkg::*;

	localparam int NUM_SCN = 5;
	localparam int LIMIT = NUM_SCN * (CFG_COUNT + CFG_RETRY_MAX + 1) * 70 * 2 * I2C_TICK_DIV + 2000;

	logic       CLOCK;
	logic       RESET;
	logic       start;
	logic       clear;
	int         refuse_at;
	int         refuse_times;
	logic       i2c_sclk;
	logic       i2c_sda_oe;
	logic       slave_oe;
	logic       frame_err;
	wire        sda;
	logic       cfg_busy;
	logic       cfg_done;
	logic       cfg_fail;
	cfg_index_t cfg_index;
	int         cycles = 0;
	int         seed;
	xfer_word_t exp_q [$];

	// Scenario table of refusals, failure expected, stray start and refused entry
	int   scn_refuse [NUM_SCN] = '{0, 2, CFG_RETRY_MAX, CFG_RETRY_MAX + 1, 0};
	logic scn_fail   [NUM_SCN] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	logic scn_mid    [NUM_SCN] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	int   scn_entry  [NUM_SCN];

	assign sda = ~(i2c_sda_oe | slave_oe); // Open drain bus

	codec_cfg_top u_dut (
		.CLOCK      (CLOCK),
		.RESET      (RESET),
		.start      (start),
		.i2c_sda_in (sda),
		.i2c_sclk   (i2c_sclk),
		.i2c_sda_oe (i2c_sda_oe),
		.cfg_busy   (cfg_busy),
		.cfg_done   (cfg_done),
		.cfg_fail   (cfg_fail),
		.cfg_index  (cfg_index)
	);

	i2c_slave_model u_slave (
		.scl          (i2c_sclk),
		.sda          (sda),
		.clear        (clear),
		.refuse_at    (refuse_at),
		.refuse_times (refuse_times),
		.sda_oe       (slave_oe),
		.frame_err    (frame_err)
	);

	initial begin
		CLOCK = 1'b0;
		forever #5 CLOCK = ~CLOCK;
	end

	task automatic stop_failed();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_word(input int n, input xfer_word_t got, input xfer_word_t exp);
		if (got !== exp) begin
			$display("[ERROR] log_mem[%0d] got %h expected %h", n, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_status(input cfg_index_t idx, input logic [2:0] flags,
			input cfg_index_t exp_idx, input logic [2:0] exp_flags);
		if (idx !== exp_idx) begin
			$display("[ERROR] cfg_index got %h expected %h", idx, exp_idx);
			stop_failed();
		end else if (flags !== exp_flags) begin // busy, done, fail
			$display("[ERROR] cfg_busy/done/fail got %h expected %h", flags, exp_flags);
			stop_failed();
		end
	endtask

	task automatic check_bus(input logic scl, input logic oe);
		if (scl !== 1'b1 || oe !== 1'b0) begin
			$display("[ERROR] i2c_sclk/i2c_sda_oe got %h/%h expected 1/0", scl, oe);
			stop_failed();
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] log_count got %h expected %h", got, exp);
			stop_failed();
		end
	endtask

	// Words the slave should see, from the table and the retry rule
	task automatic build_expected(input int e, input int k);
		int         n;
		xfer_word_t w;
		exp_q.delete();
		for (int i = 0; i < CFG_COUNT; i++) begin
			n = 1;
			if (i == e)
				n = (k > CFG_RETRY_MAX) ? CFG_RETRY_MAX + 1 : k + 1;
			w.dev_addr = CODEC_DEV_ADDR;
			w.reg_word = CFG_TABLE[i];
			repeat (n) exp_q.push_back(w);
			if (i == e && k > CFG_RETRY_MAX)
				break; // Gives up on this entry
		end
	endtask

	always @(posedge CLOCK) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout, configuration run did not finish in time");
			stop_failed();
		end
	end

	always @(posedge frame_err) begin
		$display("Malformed I2C frame seen by the slave model");
		stop_failed();
	end

	initial begin
		RESET = 1'b0;
		start = 1'b0;
		clear = 1'b0;
		refuse_at = 0;
		refuse_times = 0;
		seed = 44;
		for (int s = 0; s < NUM_SCN; s++)
			scn_entry[s] = $unsigned($random(seed)) % CFG_COUNT;
		repeat (3) @(negedge CLOCK);
		RESET = 1'b1;
		repeat (5) @(negedge CLOCK);
		// Idle bus and quiet status before any start
		check_bus(i2c_sclk, i2c_sda_oe);
		check_status(cfg_index, {cfg_busy, cfg_done, cfg_fail}, '0, 3'b000);
		for (int s = 0; s < NUM_SCN; s++) begin
			build_expected(scn_entry[s], scn_refuse[s]);
			@(negedge CLOCK);
			refuse_at = scn_entry[s];
			refuse_times = scn_refuse[s];
			clear = 1'b1;
			@(negedge CLOCK);
			clear = 1'b0;
			start = 1'b1;
			@(negedge CLOCK);
			start = 1'b0;
			// Busy on entry 0 one clock after start
			check_status(cfg_index, {cfg_busy, cfg_done, cfg_fail}, '0, 3'b100);
			if (scn_mid[s]) begin
				while (u_slave.log_count < 3)
					@(negedge CLOCK);
				start = 1'b1; // Should be ignored while busy
				@(negedge CLOCK);
				start = 1'b0;
			end
			while (!cfg_done && !cfg_fail)
				@(negedge CLOCK);
			if (scn_fail[s])
				check_status(cfg_index, {cfg_busy, cfg_done, cfg_fail},
					cfg_index_t'(scn_entry[s]), 3'b001);
			else
				check_status(cfg_index, {cfg_busy, cfg_done, cfg_fail}, CFG_LAST, 3'b010);
			check_count(u_slave.log_count, exp_q.size());
			for (int i = 0; i < exp_q.size(); i++)
				check_word(i, xfer_word_t'(u_slave.log_mem[i]), exp_q[i]);
			check_bus(i2c_sclk, i2c_sda_oe);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hw/i2c_bus_pkg.sv
hw/codec_cfg_pkg.sv
hw/i2c_xfer_if.sv
hw/i2c_tick_gen.sv
hw/i2c_write_ctrl.sv
hw/codec_cfg_regs.sv
hw/codec_cfg_top.sv
tb/i2c_slave_model.sv
tb/codec_cfg_asserts.sv
tb/codec_cfg_tb.sv

// File: Makefile
# Verilator build and run for the codec configuration testbench
VERILATOR ?= verilator
TOP       ?= codec_cfg_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
